//--- ifu_top.f
+incdir+.
ifu_pkg.sv
ifu_ctrl.sv
ifu_pc_gen.sv
ifu_pipe.sv
ifu_top.sv
tb_ifu_mem.sv
tb_ifu_top.sv

//--- tb_ifu_top.sv
/*
 fetch unit testbench
 directed tests for reset, sequential fetch, jump, flush, decode stall
 and bus back-pressure, checked against a model of the decode stream
 */

`timescale 1ns/1ps
`default_nettype none

`include "ifu_defines.svh"

module tb_ifu_top
    import ifu_pkg::*;
();

    localparam int          CLK_PERIOD     = 20;
    localparam int unsigned TIMEOUT_CYCLES = 2000;            // tests need about 600
    localparam logic [31:0] MEM_PATTERN    = 32'h5a5a_c3c3;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       jump_flag, flush_flag, stall_if;
    inst_addr_t jump_addr, flush_addr;
    logic       hold_low, hold_high;                   // memory ready overrides
    logic       arready, req, rsp_valid, inst_valid;
    inst_addr_t req_addr, rsp_addr, inst_addr;
    inst_data_t rsp_inst, inst;

    inst_addr_t  exp_addr = `PC_RESET_ADDR;    // next address decode should take
    int unsigned consumed = 0;                 // words checked so far
    int unsigned cycle_cnt = 0;
    logic        redir_seen = 1'b0;            // jump or flush in the previous cycle
    inst_addr_t  redir_target;
    logic        stall_seen = 1'b0;            // stall in the previous cycle
    logic        prev_valid;
    inst_data_t  prev_inst;
    inst_addr_t  prev_addr;

    always #(CLK_PERIOD/2) clk = ~clk;

    ifu_top dut_i (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .jump_flag_i  (jump_flag),
        .jump_addr_i  (jump_addr),
        .flush_flag_i (flush_flag),
        .flush_addr_i (flush_addr),
        .stall_if_i   (stall_if),
        .arready_i    (arready),
        .req_o        (req),
        .req_addr_o   (req_addr),
        .rsp_valid_i  (rsp_valid),
        .rsp_inst_i   (rsp_inst),
        .rsp_addr_i   (rsp_addr),
        .inst_o       (inst),
        .inst_addr_o  (inst_addr),
        .inst_valid_o (inst_valid)
    );

    tb_ifu_mem #(.PATTERN(MEM_PATTERN)) u_mem (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .hold_low_i  (hold_low),
        .hold_high_i (hold_high),
        .req_i       (req),
        .req_addr_i  (req_addr),
        .arready_o   (arready),
        .rsp_valid_o (rsp_valid),
        .rsp_inst_o  (rsp_inst),
        .rsp_addr_o  (rsp_addr)
    );

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("FAIL at time %0t: %s is %h, expected %h", $time, what, got, expected);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: tests still running after %0d cycles", cycle_cnt);
            $display("TESTBENCH FAILED");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    // decode stream model, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (redir_seen) begin       // cycle after a jump or flush
                assert (inst_valid === 1'b0) else report_mismatch("inst_valid_o", inst_valid, 0);
                assert (inst === `INST_NOP) else report_mismatch("inst_o", inst, `INST_NOP);
                assert (req_addr === redir_target)
                    else report_mismatch("req_addr_o", req_addr, redir_target);
            end
            if (stall_seen) begin       // outputs frozen by the stall
                assert (inst_valid === prev_valid)
                    else report_mismatch("inst_valid_o", inst_valid, prev_valid);
                assert (inst === prev_inst) else report_mismatch("inst_o", inst, prev_inst);
                assert (inst_addr === prev_addr)
                    else report_mismatch("inst_addr_o", inst_addr, prev_addr);
            end
            if (inst_valid === 1'b1 && !stall_if) begin     // decode takes it
                assert (inst_addr === exp_addr)
                    else report_mismatch("inst_addr_o", inst_addr, exp_addr);
                assert (inst === (exp_addr ^ MEM_PATTERN))
                    else report_mismatch("inst_o", inst, exp_addr ^ MEM_PATTERN);
                exp_addr = exp_addr + 32'd4;
                consumed = consumed + 1;
            end
            redir_seen   = jump_flag || flush_flag;
            redir_target = jump_flag ? jump_addr : flush_addr;     // jump wins
            if (redir_seen) begin
                exp_addr = redir_target;
            end
            stall_seen = stall_if && !redir_seen;
            prev_valid = inst_valid;
            prev_inst  = inst;
            prev_addr  = inst_addr;
        end
    end

    task automatic wait_consumed(input int unsigned n);
        int unsigned target;
        target = consumed + n;
        while (consumed < target) begin
            @(posedge clk);
        end
    endtask

    task automatic pulse_jump(input inst_addr_t target);
        @(posedge clk);
        jump_flag <= 1'b1;
        jump_addr <= target;
        @(posedge clk);
        jump_flag <= 1'b0;
    endtask

    task automatic pulse_flush(input inst_addr_t target);
        @(posedge clk);
        flush_flag <= 1'b1;
        flush_addr <= target;
        @(posedge clk);
        flush_flag <= 1'b0;
    endtask

    task automatic check_reset();
        @(negedge clk);
        assert (req === 1'b0) else report_mismatch("req_o in reset", req, 0);
        assert (inst_valid === 1'b0) else report_mismatch("inst_valid_o in reset", inst_valid, 0);
        assert (req_addr === `PC_RESET_ADDR)
            else report_mismatch("req_addr_o in reset", req_addr, `PC_RESET_ADDR);
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);     // first cycle out of reset
        assert (req === 1'b0) else report_mismatch("req_o after reset", req, 0);
        assert (inst_valid === 1'b0) else report_mismatch("inst_valid_o", inst_valid, 0);
        assert (req_addr === `PC_RESET_ADDR)
            else report_mismatch("req_addr_o after reset", req_addr, `PC_RESET_ADDR);
        wait_consumed(1);   // model starts at the boot address
    endtask

    task automatic check_sequential();
        wait_consumed(100);
    endtask

    task automatic check_jump();
        pulse_jump(32'h8000_1000);
        wait_consumed(20);
        pulse_jump(32'h8000_0100);  // backwards
        wait_consumed(10);
    endtask

    task automatic check_flush();
        pulse_flush(32'h8000_3000);
        wait_consumed(15);
        hold_low <= 1'b1;           // flush with the bus stalled
        repeat (4) @(posedge clk);
        pulse_flush(32'h8000_4000);
        repeat (3) @(posedge clk);
        hold_low <= 1'b0;
        wait_consumed(15);
    endtask

    task automatic check_stall(input logic ready_high);
        hold_high <= ready_high;
        wait_consumed(5);
        @(posedge clk);
        stall_if <= 1'b1;
        repeat (8) @(posedge clk);
        stall_if <= 1'b0;
        wait_consumed(20);          // refetched stream continues without a gap
        hold_high <= 1'b0;
    endtask

    task automatic check_backpressure();
        inst_addr_t held_addr;
        int         i;
        @(posedge clk);
        hold_low <= 1'b1;
        repeat (4) @(posedge clk);  // let the last response drain
        @(negedge clk);
        held_addr = req_addr;
        for (i = 0; i < 10; i++) begin
            @(negedge clk);
            assert (req_addr === held_addr)
                else report_mismatch("req_addr_o under back-pressure", req_addr, held_addr);
            assert (inst_valid === 1'b0)
                else report_mismatch("inst_valid_o under back-pressure", inst_valid, 0);
        end
        @(posedge clk);
        hold_low <= 1'b0;
        wait_consumed(15);
    endtask

    initial begin
        rst_n      = 1'b0;
        jump_flag  = 1'b0;
        jump_addr  = '0;
        flush_flag = 1'b0;
        flush_addr = '0;
        stall_if   = 1'b0;
        hold_low   = 1'b0;
        hold_high  = 1'b0;
        @(posedge clk);             // second edge ends reset
        check_reset();
        check_sequential();
        check_jump();
        check_flush();
        check_stall(1'b1);          // steady ready, refetch every stalled match
        check_stall(1'b0);
        check_backpressure();
        repeat (2) @(posedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_ifu_mem.sv
/*
 testbench instruction memory
 takes fetch requests under a pseudo-random or forced ready level
 and answers each taken request one cycle later with a pseudo-word
 */

`timescale 1ns/1ps
`default_nettype none

module tb_ifu_mem
    import ifu_pkg::*;
#(
    parameter logic [31:0] PATTERN = 32'h5a5a_c3c3,   // xor mask for the pseudo-word
    parameter logic [31:0] SEED    = 32'hc2f4_25df    // ready generator start state
) (
    input  wire               clk,
    input  wire               rst_n_i,
    input  wire               hold_low_i,      // force ready low
    input  wire               hold_high_i,     // force ready high
    input  wire               req_i,           // fetch request
    input  wire  inst_addr_t  req_addr_i,      // fetch address
    output logic              arready_o,       // ready level
    output logic              rsp_valid_o,     // one pulse per taken request
    output inst_data_t        rsp_inst_o,      // pseudo-word
    output inst_addr_t        rsp_addr_o       // echoed address
);

    logic [31:0] rng_q;     // xorshift state
    logic        taken;     // request accepted this cycle

    // 32-bit xorshift step
    function automatic logic [31:0] next_rand(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    assign taken = req_i && arready_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rng_q       <= SEED;
            arready_o   <= 1'b0;
            rsp_valid_o <= 1'b0;
            rsp_inst_o  <= '0;
            rsp_addr_o  <= '0;
        end else begin
            rng_q <= next_rand(rng_q);
            if (hold_low_i) begin
                arready_o <= 1'b0;
            end else if (hold_high_i) begin
                arready_o <= 1'b1;
            end else begin
                arready_o <= (rng_q[1:0] != 2'b00);     // low on about a quarter of cycles
            end
            rsp_valid_o <= taken;
            if (taken) begin
                rsp_inst_o <= req_addr_i ^ PATTERN;     // whole address goes into the word
                rsp_addr_o <= req_addr_i;
            end
        end
    end

endmodule

`default_nettype wire

//--- ifu_top.sv
/*
 instruction fetch unit top
 connects the fetch controller, PC generator and IF/ID register
 to the request bus and the decode stage
 */

`timescale 1ns/1ps
`default_nettype none

`include "ifu_defines.svh"

module ifu_top
    import ifu_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n_i,

    // execute and pipeline control
    input  wire               jump_flag_i,     // jump strobe
    input  wire  inst_addr_t  jump_addr_i,     // jump target
    input  wire               flush_flag_i,    // flush strobe
    input  wire  inst_addr_t  flush_addr_i,    // flush restart address
    input  wire               stall_if_i,      // decode stall level

    // request bus
    input  wire               arready_i,       // bus ready level
    output wire               req_o,           // fetch request
    output wire  inst_addr_t  req_addr_o,      // fetch address

    // response bus
    input  wire               rsp_valid_i,     // response pulse
    input  wire  inst_data_t  rsp_inst_i,      // instruction word
    input  wire  inst_addr_t  rsp_addr_i,      // echoed address

    // decode side
    output wire  inst_data_t  inst_o,
    output wire  inst_addr_t  inst_addr_o,
    output wire               inst_valid_o
);

    wire               redir;          // pc steer strobe
    wire redir_cause_e redir_cause;    // steer reason
    wire inst_addr_t   redir_addr;     // steer target
    wire               accept;         // response goes into IF/ID
    wire               flush;          // IF/ID bubble

    ifu_ctrl u_ifu_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .jump_flag_i  (jump_flag_i),
        .jump_addr_i  (jump_addr_i),
        .flush_flag_i (flush_flag_i),
        .flush_addr_i (flush_addr_i),
        .stall_if_i   (stall_if_i),
        .rsp_valid_i  (rsp_valid_i),
        .rsp_addr_i   (rsp_addr_i),
        .req_o        (req_o),
        .redir_o      (redir),
        .redir_cause_o(redir_cause),
        .redir_addr_o (redir_addr),
        .accept_o     (accept),
        .flush_o      (flush)
    );

    ifu_pc_gen u_ifu_pc_gen (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .redir_i      (redir),
        .redir_cause_i(redir_cause),
        .redir_addr_i (redir_addr),
        .arready_i    (arready_i),     // straight from bus
        .req_i        (req_o),
        .pc_o         (req_addr_o)     // pc is the request address
    );

    ifu_pipe u_ifu_pipe (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_i       (rsp_inst_i),
        .inst_addr_i  (rsp_addr_i),
        .accept_i     (accept),
        .flush_i      (flush),
        .stall_i      (stall_if_i),
        .inst_o       (inst_o),
        .inst_addr_o  (inst_addr_o),
        .inst_valid_o (inst_valid_o)
    );

endmodule

`default_nettype wire

//--- ifu_pipe.sv
/*
 IF/ID pipeline register
 passes an accepted instruction and its address to decode, holds
 on a stall and drops to a NOP bubble on a flush
 */

`timescale 1ns/1ps
`default_nettype none

`include "ifu_defines.svh"

module ifu_pipe
    import ifu_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n_i,

    input  wire  inst_data_t  inst_i,          // word from bus response
    input  wire  inst_addr_t  inst_addr_i,     // its address
    input  wire               accept_i,        // controller took the word
    input  wire               flush_i,         // insert a bubble
    input  wire               stall_i,         // decode holding

    output inst_data_t        inst_o,          // to decode
    output inst_addr_t        inst_addr_o,     // to decode
    output logic              inst_valid_o     // decode may consume
);

    // valid flag, the only control state here
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            inst_valid_o <= 1'b0;
        end else if (flush_i) begin
            inst_valid_o <= 1'b0;           // bubble
        end else if (!stall_i) begin
            inst_valid_o <= accept_i;       // empty slot if nothing came in
        end
    end

    // payload, loaded only when something useful arrives
    always_ff @(posedge clk) begin
        if (flush_i) begin
            inst_o <= `INST_NOP;            // address left as is
        end else if (!stall_i && accept_i) begin
            inst_o      <= inst_i;
            inst_addr_o <= inst_addr_i;
        end
    end

    // decode never sees a valid slot with an unknown payload
    a_valid_known : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        inst_valid_o |-> !$isunknown({inst_o, inst_addr_o})
    ) else $error("IF/ID valid with unknown instruction or address");

endmodule

`default_nettype wire

//--- ifu_pc_gen.sv
/*
 program counter generator
 holds the fetch pc and picks the next one from redirect target,
 sequential step on a taken request, or hold under back-pressure
 */

`timescale 1ns/1ps
`default_nettype none

`include "ifu_defines.svh"

module ifu_pc_gen
    import ifu_pkg::*;
(
    input  wire                clk,
    input  wire                rst_n_i,

    input  wire                redir_i,        // steer strobe from controller
    input  wire  redir_cause_e redir_cause_i,  // reason for the steer
    input  wire  inst_addr_t   redir_addr_i,   // steer target
    input  wire                arready_i,      // bus can take a request
    input  wire                req_i,          // request is being driven

    output inst_addr_t         pc_o            // current fetch address
);

    inst_addr_t pc_nxt;     // next pc value
    logic       req_taken;  // bus took the request this cycle

    assign req_taken = req_i && arready_i;

    // redirect first, then advance only on a taken request
    always_comb begin
        if (redir_i) begin
            pc_nxt = redir_addr_i;
        end else if (req_taken) begin
            pc_nxt = pc_o + `INST_STEP;
        end else begin
            pc_nxt = pc_o;                  // back-pressure, repeat request
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_o <= `PC_RESET_ADDR;
        end else begin
            pc_o <= pc_nxt;
        end
    end

    // word aligned fetch only, no compressed support
    a_pc_align : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        pc_o[1:0] == 2'b00
    ) else $error("misaligned pc %h", pc_o);

    // steer targets land on a word boundary
    a_redir_align : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        redir_i |-> (redir_addr_i[1:0] == 2'b00)
    ) else $error("%s target %h not word aligned", redir_cause_i.name(), redir_addr_i);

endmodule

`default_nettype wire

//--- ifu_ctrl.sv
/*
 fetch controller
 tracks the address decode expects next, accepts or drops bus
 responses against it, and raises pc redirects for jump, flush
 and refetch after a stalled response
 */

`timescale 1ns/1ps
`default_nettype none

`include "ifu_defines.svh"

module ifu_ctrl
    import ifu_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n_i,

    input  wire               jump_flag_i,     // execute jump strobe
    input  wire  inst_addr_t  jump_addr_i,     // jump target
    input  wire               flush_flag_i,    // pipeline flush strobe
    input  wire  inst_addr_t  flush_addr_i,    // flush restart address
    input  wire               stall_if_i,      // decode cannot take a word

    input  wire               rsp_valid_i,     // bus response pulse
    input  wire  inst_addr_t  rsp_addr_i,      // echoed request address

    output logic              req_o,           // fetch request to bus
    output logic              redir_o,         // steer pc this cycle
    output redir_cause_e      redir_cause_o,   // reason for the steer
    output inst_addr_t        redir_addr_o,    // new pc on redirect
    output logic              accept_o,        // load response into IF/ID
    output logic              flush_o          // bubble the IF/ID register
);

    inst_addr_t exp_addr_q;     // next address decode should see
    logic       rst_done_q;     // low for one cycle after reset release
    logic       rsp_match;      // response is the expected word
    logic       refetch;        // expected word arrived while stalled

    // keeps req_o quiet in the first cycle out of reset
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rst_done_q <= 1'b0;
        end else begin
            rst_done_q <= 1'b1;
        end
    end

    assign rsp_match = rsp_valid_i && (rsp_addr_i == exp_addr_q);   // stale words miss here
    assign refetch   = rsp_match && stall_if_i;                     // word is lost, go back

    // jump beats flush, flush beats refetch
    always_comb begin
        redir_cause_o = REDIR_NONE;
        redir_addr_o  = exp_addr_q;     // refetch target by default
        if (jump_flag_i) begin
            redir_cause_o = REDIR_JUMP;
            redir_addr_o  = jump_addr_i;
        end else if (flush_flag_i) begin
            redir_cause_o = REDIR_FLUSH;
            redir_addr_o  = flush_addr_i;
        end else if (refetch) begin
            redir_cause_o = REDIR_REFETCH;
        end
    end

    assign redir_o  = (redir_cause_o != REDIR_NONE);
    assign req_o    = rst_done_q && !redir_o;                       // no request while steering
    assign accept_o = rsp_match && !stall_if_i && !redir_o;
    assign flush_o  = jump_flag_i || flush_flag_i;                  // refetch keeps stalled outputs

    // expected address follows redirects and accepted words
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            exp_addr_q <= `PC_RESET_ADDR;
        end else if (redir_o) begin
            exp_addr_q <= redir_addr_o;             // restart point
        end else if (accept_o) begin
            exp_addr_q <= exp_addr_q + `INST_STEP;  // next word in order
        end
    end

    // expected address stays on a word boundary
    a_exp_align : assert property (
        @(posedge clk) disable iff (!rst_n_i)
        exp_addr_q[1:0] == 2'b00
    ) else $error("expected address %h not word aligned", exp_addr_q);

endmodule

`default_nettype wire

//--- ifu_pkg.sv
/*
 ifu type package
 address, instruction and redirect-cause types shared by the
 fetch controller, PC generator and IF/ID register
 */

`default_nettype none

`include "ifu_defines.svh"

package ifu_pkg;

    // fetch address, byte granular
    typedef logic [`INST_ADDR_WIDTH-1:0] inst_addr_t;

    // raw instruction word from memory
    typedef logic [`INST_DATA_WIDTH-1:0] inst_data_t;

    // why the pc is being steered this cycle
    typedef enum logic [1:0] {
        REDIR_NONE    = 2'd0,   // sequential fetch
        REDIR_JUMP    = 2'd1,   // execute took a jump
        REDIR_FLUSH   = 2'd2,   // external pipeline flush
        REDIR_REFETCH = 2'd3    // matching word lost to a decode stall
    } redir_cause_e;

endpackage

`default_nettype wire

//--- ifu_defines.svh
/*
 ifu shared constants
 widths of fetch addresses and instruction words, the boot address
 and the bubble encoding used by the IF/ID register
 */

`ifndef IFU_DEFINES_SVH
`define IFU_DEFINES_SVH

// datapath widths
`define INST_ADDR_WIDTH 32          // byte address of an instruction
`define INST_DATA_WIDTH 32          // one uncompressed instruction word

// address stepping
`define INST_STEP       32'd4       // bytes per instruction word

// boot vector
`define PC_RESET_ADDR   32'h8000_0000   // first fetch after reset

// bubble
`define INST_NOP        32'h0000_0013   // addi x0,x0,0

`endif
